// ==== Bender.yml ====
package:
  name: rv64_decode

sources:
  # decode stage RTL
  - include_dirs:
      - logic
    files:
      - logic/decode_pkg.sv
      - logic/decode_ctrl_if.sv
      - logic/ctrl_decoder.sv
      - logic/imm_gen.sv
      - logic/id_ex_reg.sv
      - logic/decode_top.sv

  # testbench
  - target: test
    include_dirs:
      - logic
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_decode_top.sv

// ==== logic/ctrl_decoder.sv ====
// control decoder
// maps opcode and funct3 onto register enables, alu and jump controls,
// the immediate format and an illegal flag
`timescale 1ns/10ps
`default_nettype none

`include "decode_config.svh"

module ctrl_decoder (
    input  decode_pkg::inst_t inst,
    decode_ctrl_if.decoder    ctrl
);

    // instruction fragments
    decode_pkg::opcode_t opcode;
    decode_pkg::funct3_t inst_funct3;

    assign opcode      = inst[6:0];
    assign inst_funct3 = inst[14:12];

    always_comb begin
        // defaults straight from the encoding
        ctrl.rs1    = inst[19:15];
        ctrl.rs2    = inst[24:20];
        ctrl.rd     = inst[11:7];
        ctrl.funct3 = inst_funct3;
        ctrl.funct7 = inst[31:25];

        // all flags low until an opcode claims them
        ctrl.keep_pc_plus_immed = 1'b0;
        ctrl.alu_use_immed      = 1'b0;
        ctrl.alu_width_32       = 1'b0;
        ctrl.jump_if            = `JUMP_NO;
        ctrl.jump_absolute      = 1'b0;
        ctrl.imm_sel            = `IMM_NONE;
        ctrl.illegal            = 1'b0;
        {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b000;

        case (opcode)
            // upper immediates, alu computes r0 + imm
            `OP_LUI, `OP_AUIPC: begin
                ctrl.imm_sel       = `IMM_U;
                ctrl.rs1           = '0;
                ctrl.funct3        = `F3OP_ADD_SUB;
                ctrl.funct7        = '0;
                ctrl.alu_use_immed = 1'b1;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b001;
                // pc adder result replaces the alu result
                ctrl.keep_pc_plus_immed = (opcode == `OP_AUIPC);
            end

            // pc-relative jump, rd gets the return address
            `OP_JAL: begin
                ctrl.imm_sel       = `IMM_UJ;
                ctrl.rs1           = '0;
                ctrl.funct3        = `F3OP_ADD_SUB;
                ctrl.funct7        = '0;
                ctrl.alu_use_immed = 1'b1;
                ctrl.jump_if       = `JUMP_YES;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b001;
            end

            // absolute jump to rs1 + imm out of the alu
            `OP_JALR: begin
                ctrl.imm_sel       = `IMM_I;
                ctrl.funct3        = `F3OP_ADD_SUB;
                ctrl.funct7        = '0;
                ctrl.alu_use_immed = 1'b1;
                ctrl.jump_if       = `JUMP_YES;
                ctrl.jump_absolute = 1'b1;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b101;
            end

            // compare in the alu, target is pc + imm
            `OP_BRANCH: begin
                ctrl.imm_sel = `IMM_SB;
                ctrl.funct7  = '0;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b110;
                case (inst_funct3)
                    // subtract, equal when difference is zero
                    `F3B_BEQ: begin
                        ctrl.funct3  = `F3OP_ADD_SUB;
                        ctrl.funct7  = `F7_SUB;
                        ctrl.jump_if = `JUMP_ALU_EQZ;
                    end
                    `F3B_BNE: begin
                        ctrl.funct3  = `F3OP_ADD_SUB;
                        ctrl.funct7  = `F7_SUB;
                        ctrl.jump_if = `JUMP_ALU_NEZ;
                    end
                    // slt gives 1 when less than
                    `F3B_BLT: begin
                        ctrl.funct3  = `F3OP_SLT;
                        ctrl.jump_if = `JUMP_ALU_NEZ;
                    end
                    `F3B_BLTU: begin
                        ctrl.funct3  = `F3OP_SLTU;
                        ctrl.jump_if = `JUMP_ALU_NEZ;
                    end
                    // not less than means greater or equal
                    `F3B_BGE: begin
                        ctrl.funct3  = `F3OP_SLT;
                        ctrl.jump_if = `JUMP_ALU_EQZ;
                    end
                    `F3B_BGEU: begin
                        ctrl.funct3  = `F3OP_SLTU;
                        ctrl.jump_if = `JUMP_ALU_EQZ;
                    end
                    // 010 and 011 are reserved
                    default: ctrl.illegal = 1'b1;
                endcase
            end

            // address calc rs1 + imm
            `OP_LOAD: begin
                ctrl.imm_sel       = `IMM_I;
                ctrl.funct3        = `F3OP_ADD_SUB;
                ctrl.funct7        = '0;
                ctrl.alu_use_immed = 1'b1;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b101;
            end
            // rs2 is the store data
            `OP_STORE: begin
                ctrl.imm_sel       = `IMM_S;
                ctrl.funct3        = `F3OP_ADD_SUB;
                ctrl.funct7        = '0;
                ctrl.alu_use_immed = 1'b1;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b110;
            end

            // alu op comes from funct3 as encoded
            `OP_OP_IMM, `OP_IMM_32: begin
                ctrl.imm_sel       = `IMM_I;
                ctrl.funct7        = '0;
                ctrl.alu_use_immed = 1'b1;
                ctrl.alu_width_32  = (opcode == `OP_IMM_32);
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b101;
            end
            // register-register, funct3 and funct7 pass through
            `OP_OP, `OP_OP_32: begin
                ctrl.alu_width_32 = (opcode == `OP_OP_32);
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b111;
            end

            // fence and system ops go down the pipe as no-ops
            `OP_MISC_MEM, `OP_SYSTEM: begin
                ctrl.funct7 = '0;
            end

            default: ctrl.illegal = 1'b1;
        endcase

        // illegal ops must not touch registers or redirect fetch
        if (ctrl.illegal) begin
            {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b000;
            ctrl.jump_if       = `JUMP_NO;
            ctrl.jump_absolute = 1'b0;
        end
    end

    // no register traffic from an illegal op, whatever the opcode path
    a_illegal_no_en: assert final ($isunknown(inst) || !ctrl.illegal ||
                                   !(ctrl.en_rs1 || ctrl.en_rs2 || ctrl.en_rd))
        else $error("illegal instruction with a register enable set");

    // absolute target only for an unconditional jump
    a_abs_uncond: assert final ($isunknown(inst) || !ctrl.jump_absolute ||
                                ctrl.jump_if == `JUMP_YES)
        else $error("jump_absolute without jump_if JUMP_YES");

endmodule

`default_nettype wire

// ==== logic/decode_config.svh ====
// decode stage configuration
// widths, RISC-V opcodes, funct3 codes, jump codes and immediate formats
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// datapath and field widths
`define XLEN        64
`define INST_W      32
`define REG_ADDR_W  5
`define OPCODE_W    7
`define FUNCT3_W    3
`define FUNCT7_W    7
`define JUMP_W      2
`define IMM_SEL_W   3

// base opcodes, inst[6:0]
`define OP_LUI      7'b011_0111
`define OP_AUIPC    7'b001_0111
`define OP_JAL      7'b110_1111
`define OP_JALR     7'b110_0111
`define OP_BRANCH   7'b110_0011
`define OP_LOAD     7'b000_0011
`define OP_STORE    7'b010_0011
`define OP_OP_IMM   7'b001_0011
`define OP_IMM_32   7'b001_1011
`define OP_OP       7'b011_0011
`define OP_OP_32    7'b011_1011
`define OP_MISC_MEM 7'b000_1111
`define OP_SYSTEM   7'b111_0011

// alu funct3 codes used by the decoder
`define F3OP_ADD_SUB 3'b000
`define F3OP_SLT     3'b010
`define F3OP_SLTU    3'b011

// branch funct3 codes, 010 and 011 are reserved
`define F3B_BEQ  3'b000
`define F3B_BNE  3'b001
`define F3B_BLT  3'b100
`define F3B_BGE  3'b101
`define F3B_BLTU 3'b110
`define F3B_BGEU 3'b111

// funct7 for subtract
`define F7_SUB 7'b010_0000

// jump condition codes
`define JUMP_NO      2'b00
`define JUMP_YES     2'b01
`define JUMP_ALU_EQZ 2'b10
`define JUMP_ALU_NEZ 2'b11

// immediate format select
`define IMM_NONE 3'd0
`define IMM_I    3'd1
`define IMM_S    3'd2
`define IMM_SB   3'd3
`define IMM_U    3'd4
`define IMM_UJ   3'd5

`endif

// ==== logic/decode_ctrl_if.sv ====
// decoded control bundle
// carries every decoded field except the immediate value itself
`timescale 1ns/10ps
`default_nettype none

interface decode_ctrl_if;

    // register addresses, r0 forced where the op has no rs1
    decode_pkg::reg_addr_t  rs1;
    decode_pkg::reg_addr_t  rs2;
    decode_pkg::reg_addr_t  rd;

    // register usage, for hazard detect and writeback
    logic                   en_rs1;
    logic                   en_rs2;
    logic                   en_rd;

    // execute stage controls
    logic                   keep_pc_plus_immed;
    logic                   alu_use_immed;
    logic                   alu_width_32;
    decode_pkg::funct3_t    funct3;
    decode_pkg::funct7_t    funct7;

    // jump controls
    decode_pkg::jump_code_t jump_if;
    logic                   jump_absolute;

    // immediate format and error flag
    decode_pkg::imm_sel_t   imm_sel;
    logic                   illegal;

    modport decoder (
        output rs1, rs2, rd, en_rs1, en_rs2, en_rd,
        output keep_pc_plus_immed, alu_use_immed, alu_width_32, funct3, funct7,
        output jump_if, jump_absolute, imm_sel, illegal
    );

    // immediate generator only needs the format
    modport imm (input imm_sel);

    // the pipeline register takes the whole bundle
    modport stage (
        input rs1, rs2, rd, en_rs1, en_rs2, en_rd,
        input keep_pc_plus_immed, alu_use_immed, alu_width_32, funct3, funct7,
        input jump_if, jump_absolute, illegal
    );

endinterface

`default_nettype wire

// ==== logic/decode_pkg.sv ====
// decode package
// vector types for the fields that travel through the ID stage
`default_nettype none

`include "decode_config.svh"

package decode_pkg;

    // register value or sign-extended immediate
    typedef logic [`XLEN-1:0] xlen_t;

    // raw instruction word from fetch
    typedef logic [`INST_W-1:0] inst_t;

    // architectural register index, r0 to r31
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // major opcode, inst[6:0]
    typedef logic [`OPCODE_W-1:0] opcode_t;

    // funct3 as passed to the alu
    // may differ from inst[14:12] for branches and address calc
    typedef logic [`FUNCT3_W-1:0] funct3_t;

    // funct7 as passed to the alu
    // zero unless the op needs bit 5 (sub, sra)
    typedef logic [`FUNCT7_W-1:0] funct7_t;

    // jump condition, see JUMP_* codes
    // no jump, always, or on alu result zero / nonzero
    typedef logic [`JUMP_W-1:0] jump_code_t;

    // immediate format, see IMM_* codes
    typedef logic [`IMM_SEL_W-1:0] imm_sel_t;

endpackage

`default_nettype wire

// ==== logic/decode_top.sv ====
// RV64I/M instruction decode stage
// combinational decode of one instruction per cycle, registered into ID/EX
`timescale 1ns/10ps
`default_nettype none

module decode_top (
    input  logic                   clk,
    input  logic                   reset,

    // from fetch
    input  decode_pkg::inst_t      inst,
    input  logic                   inst_valid,

    // to execute
    output logic                   out_valid,
    output decode_pkg::reg_addr_t  rs1,
    output decode_pkg::reg_addr_t  rs2,
    output decode_pkg::reg_addr_t  rd,
    output logic                   en_rs1,
    output logic                   en_rs2,
    output logic                   en_rd,
    output decode_pkg::xlen_t      immed,
    output logic                   keep_pc_plus_immed,
    output logic                   alu_use_immed,
    output logic                   alu_width_32,
    output decode_pkg::funct3_t    funct3,
    output decode_pkg::funct7_t    funct7,
    output decode_pkg::jump_code_t jump_if,
    output logic                   jump_absolute,
    output logic                   illegal
);

    // decoded fields, shared by all three blocks
    decode_ctrl_if ctrl_if ();

    // unregistered immediate
    decode_pkg::xlen_t imm_value;

    ctrl_decoder i_ctrl_decoder (
        .inst (inst),
        .ctrl (ctrl_if.decoder)
    );

    imm_gen i_imm_gen (
        .inst  (inst),
        .ctrl  (ctrl_if.imm),
        .immed (imm_value)
    );

    id_ex_reg i_id_ex_reg (
        .clk                (clk),
        .reset              (reset),
        .inst_valid         (inst_valid),
        .ctrl               (ctrl_if.stage),
        .immed              (imm_value),
        .out_valid          (out_valid),
        .rs1                (rs1),
        .rs2                (rs2),
        .rd                 (rd),
        .en_rs1             (en_rs1),
        .en_rs2             (en_rs2),
        .en_rd              (en_rd),
        .out_immed          (immed),
        .keep_pc_plus_immed (keep_pc_plus_immed),
        .alu_use_immed      (alu_use_immed),
        .alu_width_32       (alu_width_32),
        .funct3             (funct3),
        .funct7             (funct7),
        .jump_if            (jump_if),
        .jump_absolute      (jump_absolute),
        .illegal            (illegal)
    );

endmodule

`default_nettype wire

// ==== logic/id_ex_reg.sv ====
// ID/EX pipeline register
// captures the decoded bundle on a valid strobe, valid bit every cycle
`timescale 1ns/10ps
`default_nettype none

`include "decode_config.svh"

module id_ex_reg (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inst_valid,
    decode_ctrl_if.stage           ctrl,
    input  decode_pkg::xlen_t      immed,

    output logic                   out_valid,
    output decode_pkg::reg_addr_t  rs1,
    output decode_pkg::reg_addr_t  rs2,
    output decode_pkg::reg_addr_t  rd,
    output logic                   en_rs1,
    output logic                   en_rs2,
    output logic                   en_rd,
    output decode_pkg::xlen_t      out_immed,
    output logic                   keep_pc_plus_immed,
    output logic                   alu_use_immed,
    output logic                   alu_width_32,
    output decode_pkg::funct3_t    funct3,
    output decode_pkg::funct7_t    funct7,
    output decode_pkg::jump_code_t jump_if,
    output logic                   jump_absolute,
    output logic                   illegal
);

    // valid and control flags
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid          <= 1'b0;
            en_rs1             <= 1'b0;
            en_rs2             <= 1'b0;
            en_rd              <= 1'b0;
            keep_pc_plus_immed <= 1'b0;
            alu_use_immed      <= 1'b0;
            alu_width_32       <= 1'b0;
            jump_if            <= `JUMP_NO;
            jump_absolute      <= 1'b0;
            illegal            <= 1'b0;
        end else begin
            // bubbles pass through as out_valid low
            out_valid <= inst_valid;
            if (inst_valid) begin
                en_rs1             <= ctrl.en_rs1;
                en_rs2             <= ctrl.en_rs2;
                en_rd              <= ctrl.en_rd;
                keep_pc_plus_immed <= ctrl.keep_pc_plus_immed;
                alu_use_immed      <= ctrl.alu_use_immed;
                alu_width_32       <= ctrl.alu_width_32;
                jump_if            <= ctrl.jump_if;
                jump_absolute      <= ctrl.jump_absolute;
                illegal            <= ctrl.illegal;
            end
        end
    end

    // payload, held while out_valid is low
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            rs1       <= ctrl.rs1;
            rs2       <= ctrl.rs2;
            rd        <= ctrl.rd;
            out_immed <= immed;
            funct3    <= ctrl.funct3;
            funct7    <= ctrl.funct7;
        end
    end

    // nothing leaves the stage straight out of reset
    a_reset_invalid: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high the cycle after reset");

    // exactly one cycle from strobe to valid output
    a_one_cycle: assert property (@(posedge clk) disable iff (reset)
                                  !reset |=> out_valid == $past(inst_valid))
        else $error("out_valid does not follow inst_valid by one cycle");

endmodule

`default_nettype wire

// ==== logic/imm_gen.sv ====
// immediate generator
// sign-extends and unscrambles the five RISC-V immediate formats
`timescale 1ns/10ps
`default_nettype none

`include "decode_config.svh"

module imm_gen (
    input  decode_pkg::inst_t inst,
    decode_ctrl_if.imm        ctrl,
    output decode_pkg::xlen_t immed
);

    // one candidate per format, all sign-extended from inst[31]
    decode_pkg::xlen_t imm_i;
    decode_pkg::xlen_t imm_s;
    decode_pkg::xlen_t imm_sb;
    decode_pkg::xlen_t imm_u;
    decode_pkg::xlen_t imm_uj;

    // 12 bits, loads, jalr, op-imm
    assign imm_i  = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    // 12 bits split around rd field
    assign imm_s  = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    // 13 bits, halfword aligned branch offset
    assign imm_sb = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                     inst[11:8], 1'b0};
    // upper 20 bits, low 12 zero
    assign imm_u  = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    // 21 bits, jal offset
    assign imm_uj = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                     inst[30:21], 1'b0};

    // format chosen by the control decoder
    always_comb begin
        case (ctrl.imm_sel)
            `IMM_I:  immed = imm_i;
            `IMM_S:  immed = imm_s;
            `IMM_SB: immed = imm_sb;
            `IMM_U:  immed = imm_u;
            `IMM_UJ: immed = imm_uj;
            // op, misc-mem, system and illegal
            default: immed = '0;
        endcase
    end

    // branch and jal targets stay halfword aligned
    a_target_aligned: assert final ($isunknown(ctrl.imm_sel) ||
                                    !(ctrl.imm_sel == `IMM_SB ||
                                      ctrl.imm_sel == `IMM_UJ) ||
                                    immed[0] == 1'b0)
        else $error("odd immediate on a branch or jal format");

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
// testbench clock and reset
// 8 ns clock, synchronous reset held over the first 4 rising edges
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // released just after an edge, like the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== sim/tb_decode_top.sv ====
// decode stage testbench
// LFSR instructions per opcode class, checked against a reference decode
// one cycle after each valid strobe
`timescale 1ns/10ps
`default_nettype none

`include "decode_config.svh"

module tb_decode_top;

    // expected ID/EX bundle, enables packed as {rs1, rs2, rd}
    typedef struct packed {
        decode_pkg::reg_addr_t  rs1;
        decode_pkg::reg_addr_t  rs2;
        decode_pkg::reg_addr_t  rd;
        logic [2:0]             en;
        decode_pkg::xlen_t      immed;
        logic                   keep_pc_plus_immed;
        logic                   alu_use_immed;
        logic                   alu_width_32;
        decode_pkg::funct3_t    funct3;
        decode_pkg::funct7_t    funct7;
        decode_pkg::jump_code_t jump_if;
        logic                   jump_absolute;
        logic                   illegal;
    } bundle_t;

    logic                   clk;
    logic                   reset;
    decode_pkg::inst_t      inst;
    logic                   inst_valid;
    logic                   out_valid;
    decode_pkg::reg_addr_t  rs1, rs2, rd;
    logic                   en_rs1, en_rs2, en_rd;
    decode_pkg::xlen_t      immed;
    logic                   keep_pc_plus_immed, alu_use_immed, alu_width_32;
    decode_pkg::funct3_t    funct3;
    decode_pkg::funct7_t    funct7;
    decode_pkg::jump_code_t jump_if;
    logic                   jump_absolute, illegal;

    // expected bundles and the cycle each one is due
    bundle_t     exp_q[$];
    int          due_q[$];
    int          cycle_count = 0;
    int          errors = 0;
    int          checks = 0;
    int          test_errors = 0;
    string       cur_test = "reset";
    logic [31:0] lfsr_state = 32'hb3ff;

    decode_pkg::opcode_t legal_ops[13] = '{`OP_LUI, `OP_AUIPC, `OP_JAL, `OP_JALR,
        `OP_BRANCH, `OP_LOAD, `OP_STORE, `OP_OP_IMM, `OP_IMM_32, `OP_OP, `OP_OP_32,
        `OP_MISC_MEM, `OP_SYSTEM};
    decode_pkg::funct3_t branch_f3[6] = '{`F3B_BEQ, `F3B_BNE, `F3B_BLT, `F3B_BGE,
        `F3B_BLTU, `F3B_BGEU};

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    // tb signals carry the port names
    decode_top i_dut (.*);

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int nbits);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic decode_pkg::inst_t rand_inst(input decode_pkg::opcode_t op);
        logic [31:0] upper;
        upper = take_bits(25);
        return {upper[24:0], op};
    endfunction

    // expected decode of one instruction
    function automatic bundle_t decode_ref(input decode_pkg::inst_t w);
        bundle_t              b;
        decode_pkg::imm_sel_t fmt;
        logic signed [11:0]   i_imm;
        logic signed [11:0]   s_imm;
        logic signed [12:0]   b_imm;
        logic signed [31:0]   u_imm;
        logic signed [20:0]   j_imm;
        i_imm = w[31:20];
        s_imm = {w[31:25], w[11:7]};
        b_imm = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        u_imm = {w[31:12], 12'h000};
        j_imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        b        = '0;
        b.rs1    = w[19:15];
        b.rs2    = w[24:20];
        b.rd     = w[11:7];
        b.funct3 = w[14:12];
        b.jump_if = `JUMP_NO;
        fmt      = `IMM_NONE;
        // every legal opcode but OP and OP-32 clears funct7
        if (w[6:0] != `OP_OP && w[6:0] != `OP_OP_32)
            b.funct7 = '0;
        else
            b.funct7 = w[31:25];
        case (w[6:0])
            `OP_LUI, `OP_AUIPC, `OP_JAL: begin
                b.rs1 = '0;
                b.en  = 3'b001;
                fmt   = (w[6:0] == `OP_JAL) ? `IMM_UJ : `IMM_U;
                b.keep_pc_plus_immed = (w[6:0] == `OP_AUIPC);
                b.jump_if            = (w[6:0] == `OP_JAL) ? `JUMP_YES : `JUMP_NO;
            end
            `OP_JALR: begin
                b.en            = 3'b101;
                fmt             = `IMM_I;
                b.jump_if       = `JUMP_YES;
                b.jump_absolute = 1'b1;
            end
            `OP_LOAD: begin
                b.en = 3'b101;
                fmt  = `IMM_I;
            end
            `OP_STORE: begin
                b.en = 3'b110;
                fmt  = `IMM_S;
            end
            `OP_OP_IMM, `OP_IMM_32: begin
                b.en = 3'b101;
                fmt  = `IMM_I;
            end
            `OP_OP, `OP_OP_32:   b.en = 3'b111;
            `OP_MISC_MEM, `OP_SYSTEM: b.en = 3'b000;
            `OP_BRANCH: begin
                b.en = 3'b110;
                fmt  = `IMM_SB;
                // eq/ne by subtract, lt/ge by set-less-than
                case (w[14:12])
                    `F3B_BEQ, `F3B_BNE: begin
                        b.funct3 = `F3OP_ADD_SUB;
                        b.funct7 = `F7_SUB;
                    end
                    `F3B_BLT, `F3B_BGE:   b.funct3 = `F3OP_SLT;
                    `F3B_BLTU, `F3B_BGEU: b.funct3 = `F3OP_SLTU;
                    default:              b.illegal = 1'b1;
                endcase
                if (w[14:12] == `F3B_BEQ || w[14:12] == `F3B_BGE || w[14:12] == `F3B_BGEU)
                    b.jump_if = `JUMP_ALU_EQZ;
                else
                    b.jump_if = `JUMP_ALU_NEZ;
            end
            // unknown opcode keeps the encoded funct7
            default: begin
                b.illegal = 1'b1;
                b.funct7  = w[31:25];
            end
        endcase
        // immediate operand, added to r0 for the upper and jal forms
        if (fmt inside {`IMM_I, `IMM_S, `IMM_U, `IMM_UJ}) begin
            b.alu_use_immed = 1'b1;
            if (w[6:0] != `OP_OP_IMM && w[6:0] != `OP_IMM_32)
                b.funct3 = `F3OP_ADD_SUB;
        end
        b.alu_width_32 = (w[6:0] == `OP_IMM_32 || w[6:0] == `OP_OP_32);
        if (b.illegal) begin
            b.en            = 3'b000;
            b.jump_if       = `JUMP_NO;
            b.jump_absolute = 1'b0;
        end
        case (fmt)
            `IMM_I:  b.immed = i_imm;
            `IMM_S:  b.immed = s_imm;
            `IMM_SB: b.immed = b_imm;
            `IMM_U:  b.immed = u_imm;
            `IMM_UJ: b.immed = j_imm;
            default: b.immed = '0;
        endcase
        return b;
    endfunction

    task automatic check_value(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error: %s %s expected %0h actual %0h", cur_test, field, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // outputs have settled by the falling edge
    always @(negedge clk) begin : compare_outputs
        bundle_t head;
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s: out_valid high with no instruction pending", cur_test);
            end else begin
                head = exp_q.pop_front();
                if (due_q.pop_front() != cycle_count) begin
                    errors++;
                    $display("%s: out_valid not one cycle after its strobe", cur_test);
                end
                check_value("rs1", head.rs1, rs1);
                check_value("rs2", head.rs2, rs2);
                check_value("rd", head.rd, rd);
                check_value("enables", head.en, {en_rs1, en_rs2, en_rd});
                check_value("immed", head.immed, immed);
                check_value("keep_pc_plus_immed", head.keep_pc_plus_immed, keep_pc_plus_immed);
                check_value("alu_use_immed", head.alu_use_immed, alu_use_immed);
                check_value("alu_width_32", head.alu_width_32, alu_width_32);
                check_value("funct3", head.funct3, funct3);
                check_value("funct7", head.funct7, funct7);
                check_value("jump_if", head.jump_if, jump_if);
                check_value("jump_absolute", head.jump_absolute, jump_absolute);
                check_value("illegal", head.illegal, illegal);
            end
        end else if (!reset && due_q.size() > 0 && due_q[0] <= cycle_count) begin
            errors++;
            $display("%s: accepted instruction never came out", cur_test);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
    end

    // one instruction, 1 ns after the rising edge
    task automatic send(input decode_pkg::inst_t word);
        @(posedge clk);
        #1;
        inst       = word;
        inst_valid = 1'b1;
        exp_q.push_back(decode_ref(word));
        due_q.push_back(cycle_count + 1);
    endtask

    // junk on inst while not valid
    task automatic bubble();
        @(posedge clk);
        #1;
        inst       = take_bits(32);
        inst_valid = 1'b0;
    endtask

    task automatic check_quiet();
        check_value("out_valid", 0, out_valid);
        check_value("enables", 0, {en_rs1, en_rs2, en_rd});
        check_value("illegal", 0, illegal);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    // drain the pipe, then report the test
    task automatic finish_test(input int sent);
        int n;
        n = 0;
        bubble();
        while (exp_q.size() > 0 && n < 20) begin
            bubble();
            n++;
        end
        if (exp_q.size() > 0) begin
            errors++;
            $display("Timeout: %s still waits for %0d outputs", cur_test, exp_q.size());
            exp_q.delete();
            due_q.delete();
        end
        $display("test %-10s %0d instructions, %0d errors", cur_test, sent,
                 errors - test_errors);
    endtask

    initial begin
        int                n;
        int                sent;
        decode_pkg::inst_t word;
        inst       = '0;
        inst_valid = 1'b0;

        // quiet outputs during and after reset
        start_test("reset");
        n = 0;
        while (reset !== 1'b0 && n < 50) begin
            @(negedge clk);
            check_quiet();
            n++;
        end
        if (reset !== 1'b0) begin
            errors++;
            $display("Timeout: reset never released");
        end
        repeat (2) begin
            @(negedge clk);
            check_quiet();
        end
        finish_test(0);

        // one negative and one positive immediate per class
        start_test("immediates");
        foreach (legal_ops[i]) begin
            for (int k = 0; k < 4; k++) begin
                word = rand_inst(legal_ops[i]);
                if (k < 2)
                    word[31] = (k == 0);
                send(word);
            end
        end
        finish_test(52);

        // nonzero rs1 field, dropped for LUI, AUIPC and JAL
        start_test("registers");
        foreach (legal_ops[i]) begin
            for (int k = 0; k < 3; k++) begin
                word        = rand_inst(legal_ops[i]);
                word[19:15] = 5'(take_bits(4)) | 5'b1_0000;
                send(word);
            end
        end
        finish_test(39);

        start_test("branches");
        repeat (2) begin
            foreach (branch_f3[i]) begin
                word        = rand_inst(`OP_BRANCH);
                word[14:12] = branch_f3[i];
                send(word);
            end
            send(rand_inst(`OP_JAL));
            send(rand_inst(`OP_JALR));
        end
        finish_test(16);

        start_test("alu");
        for (int k = 0; k < 4; k++) begin
            send(rand_inst(`OP_OP_IMM));
            send(rand_inst(`OP_IMM_32));
            send(rand_inst(`OP_OP));
            send(rand_inst(`OP_OP_32));
            send(rand_inst(`OP_AUIPC));
            send(rand_inst(`OP_LUI));
            send(rand_inst(`OP_LOAD));
            send(rand_inst(`OP_STORE));
        end
        finish_test(32);

        // every base opcode ends in 11, so bit 0 low is unknown
        start_test("illegal");
        for (int k = 0; k < 6; k++) begin
            word    = take_bits(32);
            word[0] = 1'b0;
            send(word);
        end
        send(rand_inst(7'b000_0111));
        send(rand_inst(7'b111_1111));
        word        = rand_inst(`OP_BRANCH);
        word[14:12] = 3'b010;
        send(word);
        word[14:12] = 3'b011;
        send(word);
        // random strobe pattern with bubbles
        sent = 10;
        for (int k = 0; k < 60; k++) begin
            if (take_bits(1) != 0) begin
                send(rand_inst(legal_ops[take_bits(4) % 13]));
                sent++;
            end else begin
                bubble();
            end
        end
        finish_test(sent);

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+logic
logic/decode_pkg.sv
logic/decode_ctrl_if.sv
logic/ctrl_decoder.sv
logic/imm_gen.sv
logic/id_ex_reg.sv
logic/decode_top.sv
sim/tb_clock_gen.sv
sim/tb_decode_top.sv
